/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int IQ_DEPTH   = 8;
    localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);
    localparam int CDB_COUNT  = 2;
    localparam int MEM_WORDS  = 256;
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // --------------------
    // basic types
    // --------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  rob_id_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // operand either valid or waiting on tag
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } operand_t;

    typedef struct packed {
        logic      store;
        mem_size_e size;
        logic      is_signed;
        rob_id_t   rob_id;
        word_t     imm;
        operand_t  data_opnd;
        operand_t  base_opnd;
    } lsu_op_t;

    // up to two ops per cycle from dispatch
    typedef struct packed {
        lsu_op_t [1:0] slot;
        logic    [1:0] mask;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    typedef struct packed {
        logic      store;
        mem_size_e size;
        logic      is_signed;
        rob_id_t   rob_id;
        word_t     addr;
        word_t     wdata;
        logic [3:0] strb;
        logic      misaligned;
    } mem_req_t;

    typedef struct packed {
        rob_id_t rob_id;
        word_t   data;
        logic    exc;
    } result_t;

endpackage

`default_nettype wire

/* hw/iq_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_entry (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     alloc_i,
    input  lsu_pkg::lsu_op_t                         op_i,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_COUNT-1:0]   cdb_i,
    input  logic                                     issue_i,
    output logic                                     busy_o,
    output logic                                     ready_o,
    output lsu_pkg::lsu_op_t                         op_o
);
    import lsu_pkg::*;

    logic    busy_q;
    lsu_op_t op_q;
    lsu_op_t op_src;
    lsu_op_t op_d;

    // capture data from any matching broadcast
    function automatic operand_t wake(input operand_t opnd,
                                      input cdb_t [CDB_COUNT-1:0] cdb);
        operand_t res;
        res = opnd;
        for (int i = 0; i < CDB_COUNT; i++) begin
            if (!res.valid && cdb[i].valid && cdb[i].tag == opnd.tag) begin
                res.valid = 1'b1;
                res.data  = cdb[i].data;
            end
        end
        return res;
    endfunction

    // incoming op also sees this cycle's broadcasts
    always_comb begin
        op_src           = alloc_i ? op_i : op_q;
        op_d             = op_src;
        op_d.data_opnd   = wake(op_src.data_opnd, cdb_i);
        op_d.base_opnd   = wake(op_src.base_opnd, cdb_i);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (alloc_i) begin
            busy_q <= 1'b1;
        end else if (issue_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i || busy_q) begin
            op_q <= op_d;
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && op_q.data_opnd.valid && op_q.base_opnd.valid;
    assign op_o    = op_q;

endmodule

`default_nettype wire

/* hw/lsu_iq.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_iq (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  lsu_pkg::dispatch_t                       dispatch_i,
    input  logic                                     dispatch_valid_i,
    output logic                                     dispatch_ready_o,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_COUNT-1:0]   cdb_i,
    output logic                                     issue_valid_o,
    input  logic                                     issue_ready_i,
    output lsu_pkg::lsu_op_t                         issue_op_o
);
    import lsu_pkg::*;

    logic [IQ_PTR_W-1:0] head_q;
    logic [IQ_PTR_W-1:0] tail_q;
    logic [IQ_PTR_W-1:0] tail_next;
    logic [IQ_PTR_W:0]   free_q;
    logic [IQ_PTR_W:0]   free_d;

    logic                dispatch_fire;
    logic                issue_fire;
    logic [1:0]          n_alloc;
    lsu_op_t             first_op;

    logic    [IQ_DEPTH-1:0] entry_alloc;
    logic    [IQ_DEPTH-1:0] entry_issue;
    logic    [IQ_DEPTH-1:0] entry_busy;
    logic    [IQ_DEPTH-1:0] entry_ready;
    lsu_op_t [IQ_DEPTH-1:0] entry_op_in;
    lsu_op_t [IQ_DEPTH-1:0] entry_op;

    assign dispatch_fire = dispatch_valid_i && dispatch_ready_o;
    assign issue_fire    = issue_valid_o && issue_ready_i;
    assign tail_next     = tail_q + 1'b1;

    // --------------------
    // allocation
    // --------------------
    // a lone slot 1 still goes to tail
    always_comb begin
        first_op = dispatch_i.mask[0] ? dispatch_i.slot[0] : dispatch_i.slot[1];
        n_alloc  = 2'd0;
        if (dispatch_fire) begin
            n_alloc = {1'b0, dispatch_i.mask[0]} + {1'b0, dispatch_i.mask[1]};
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            entry_alloc[i] = 1'b0;
            entry_op_in[i] = first_op;
            if (IQ_PTR_W'(i) == tail_q) begin
                entry_alloc[i] = (n_alloc != 2'd0);
            end else if (IQ_PTR_W'(i) == tail_next) begin
                entry_alloc[i] = (n_alloc == 2'd2);
                entry_op_in[i] = dispatch_i.slot[1];
            end
            // only ever write a free slot
            entry_alloc[i] = entry_alloc[i] && !entry_busy[i];
            entry_issue[i] = issue_fire && (IQ_PTR_W'(i) == head_q);
        end
    end

    // --------------------
    // pointers and credit
    // --------------------
    assign free_d = free_q - (IQ_PTR_W+1)'(n_alloc) + (IQ_PTR_W+1)'(issue_fire);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            free_q           <= (IQ_PTR_W+1)'(IQ_DEPTH);
            dispatch_ready_o <= 1'b0;
        end else begin
            free_q           <= free_d;
            // room for a full two-wide dispatch
            dispatch_ready_o <= (free_d >= (IQ_PTR_W+1)'(2));
            tail_q           <= tail_q + IQ_PTR_W'(n_alloc);
            if (issue_fire) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // --------------------
    // entries
    // --------------------
    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        iq_entry iq_entry_i (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .alloc_i (entry_alloc[i]),
            .op_i    (entry_op_in[i]),
            .cdb_i   (cdb_i),
            .issue_i (entry_issue[i]),
            .busy_o  (entry_busy[i]),
            .ready_o (entry_ready[i]),
            .op_o    (entry_op[i])
        );
    end

    // strictly in order, head only
    assign issue_valid_o = entry_ready[head_q];
    assign issue_op_o    = entry_op[head_q];

endmodule

`default_nettype wire

/* hw/lsu_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  lsu_pkg::lsu_op_t  op_i,
    output lsu_pkg::mem_req_t req_o
);
    import lsu_pkg::*;

    word_t      addr;
    logic [3:0] base_strb;
    word_t      lane_data;

    always_comb begin
        addr = op_i.base_opnd.data + op_i.imm;

        // strobe at lane 0, data copied to every lane
        case (op_i.size)
            SIZE_BYTE: begin
                base_strb = 4'b0001;
                lane_data = {4{op_i.data_opnd.data[7:0]}};
            end
            SIZE_HALF: begin
                base_strb = 4'b0011;
                lane_data = {2{op_i.data_opnd.data[15:0]}};
            end
            default: begin
                base_strb = 4'b1111;
                lane_data = op_i.data_opnd.data;
            end
        endcase

        req_o.store      = op_i.store;
        req_o.size       = op_i.size;
        req_o.is_signed  = op_i.is_signed;
        req_o.rob_id     = op_i.rob_id;
        req_o.addr       = addr;
        req_o.wdata      = op_i.store ? lane_data : '0;
        req_o.strb       = base_strb << addr[1:0];
        req_o.misaligned = ((op_i.size == SIZE_HALF) && addr[0]) ||
                           ((op_i.size == SIZE_WORD) && (addr[1:0] != 2'b00));
    end

endmodule

`default_nettype wire

/* hw/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t in_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);
    import lsu_pkg::*;

    payload_t              mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W:0]   count_q;
    logic                  push;
    logic                  pop;

    assign in_ready_o  = (count_q != (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_o       = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together leave count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i;
        end
    end

endmodule

`default_nettype wire

/* hw/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic              clk,
    input  logic              rst_n_i,
    input  lsu_pkg::mem_req_t req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    output lsu_pkg::result_t  res_o,
    output logic              res_valid_o,
    input  logic              res_ready_i
);
    import lsu_pkg::*;

    word_t                          mem_q [MEM_WORDS];
    logic [$clog2(MEM_WORDS)-1:0]   idx;
    word_t                          lane;
    word_t                          load_data;
    logic                           accept;
    logic                           res_valid_q;
    result_t                        res_q;

    // output register empty or draining this cycle
    assign req_ready_o = !res_valid_q || res_ready_i;
    assign accept      = req_valid_i && req_ready_o;
    assign idx         = req_i.addr[9:2];

    // --------------------
    // load lane select
    // --------------------
    always_comb begin
        lane = mem_q[idx] >> {req_i.addr[1:0], 3'b000};
        case (req_i.size)
            SIZE_BYTE: load_data = req_i.is_signed ? {{24{lane[7]}}, lane[7:0]}
                                                   : {24'h0, lane[7:0]};
            SIZE_HALF: load_data = req_i.is_signed ? {{16{lane[15]}}, lane[15:0]}
                                                   : {16'h0, lane[15:0]};
            default:   load_data = lane;
        endcase
    end

    // store writes only strobed bytes
    always_ff @(posedge clk) begin
        if (accept && req_i.store && !req_i.misaligned) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.strb[b]) begin
                    mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (accept) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_q.rob_id <= req_i.rob_id;
            res_q.exc    <= req_i.misaligned;
            res_q.data   <= (req_i.store || req_i.misaligned) ? '0 : load_data;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  lsu_pkg::dispatch_t                       dispatch_i,
    input  logic                                     dispatch_valid_i,
    output logic                                     dispatch_ready_o,
    input  lsu_pkg::cdb_t [lsu_pkg::CDB_COUNT-1:0]   cdb_i,
    output lsu_pkg::result_t                         result_o,
    output logic                                     result_valid_o,
    input  logic                                     result_ready_i
);
    import lsu_pkg::*;

    logic     issue_valid;
    logic     issue_ready;
    lsu_op_t  issue_op;
    mem_req_t agu_req;

    mem_req_t mreq;
    logic     mreq_valid;
    logic     mreq_ready;

    result_t  mres;
    logic     mres_valid;
    logic     mres_ready;

    lsu_iq lsu_iq_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .dispatch_i       (dispatch_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_i            (cdb_i),
        .issue_valid_o    (issue_valid),
        .issue_ready_i    (issue_ready),
        .issue_op_o       (issue_op)
    );

    lsu_agu lsu_agu_i (
        .op_i  (issue_op),
        .req_o (agu_req)
    );

    // --------------------
    // request and result streams
    // --------------------
    stream_fifo #(.payload_t(mem_req_t)) req_fifo_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_i        (agu_req),
        .in_valid_i  (issue_valid),
        .in_ready_o  (issue_ready),
        .out_o       (mreq),
        .out_valid_o (mreq_valid),
        .out_ready_i (mreq_ready)
    );

    data_mem data_mem_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (mreq),
        .req_valid_i (mreq_valid),
        .req_ready_o (mreq_ready),
        .res_o       (mres),
        .res_valid_o (mres_valid),
        .res_ready_i (mres_ready)
    );

    stream_fifo #(.payload_t(result_t)) res_fifo_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_i        (mres),
        .in_valid_i  (mres_valid),
        .in_ready_o  (mres_ready),
        .out_o       (result_o),
        .out_valid_o (result_valid_o),
        .out_ready_i (result_ready_i)
    );

endmodule

`default_nettype wire

/* tests/lsu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_properties (
    input logic             clk,
    input logic             rst_n_i,
    input logic             dispatch_ready_i,
    input lsu_pkg::result_t result_i,
    input logic             result_valid_i,
    input logic             result_ready_i
);
    int error_count;

    initial begin
        error_count = 0;
    end

    // a stalled result holds its payload
    result_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
    else begin
        $error("result_o changed or dropped while result_ready_i was low");
        error_count++;
    end

    // both handshake outputs quiet while in reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !dispatch_ready_i && !result_valid_i)
    else begin
        $error("dispatch_ready_o or result_valid_o high during reset");
        error_count++;
    end

endmodule

bind lsu_top lsu_properties lsu_properties_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .dispatch_ready_i (dispatch_ready_o),
    .result_i         (result_o),
    .result_valid_i   (result_valid_o),
    .result_ready_i   (result_ready_i)
);

`default_nettype wire

/* tests/tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int RAND_OPS   = 40;
    localparam int FILL_PAIRS = 10;
    // init, word, lanes, tags, misaligned, random, fill
    localparam int N_OPS = 16 + 2 + 20 + 4 + 5 + (RAND_OPS + 1) + 2 * FILL_PAIRS;
    localparam int WATCHDOG_CYCLES = N_OPS * 40 + 200;
    localparam cdb_t [CDB_COUNT-1:0] NO_CDB = '0;

    logic                 clk;
    logic                 rst_n_i;
    dispatch_t            dispatch_i;
    logic                 dispatch_valid_i;
    logic                 dispatch_ready_o;
    cdb_t [CDB_COUNT-1:0] cdb_i;
    result_t              result_o;
    logic                 result_valid_o;
    logic                 result_ready_i;

    word_t   mem_model [MEM_WORDS];
    result_t exp_q [$];
    rob_id_t next_rob;
    integer  seed;
    integer  ready_seed;
    int      ready_mode;
    int      results_seen;

    lsu_top lsu_top_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .dispatch_i       (dispatch_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_i            (cdb_i),
        .result_o         (result_o),
        .result_valid_o   (result_valid_o),
        .result_ready_i   (result_ready_i)
    );

    always #5 clk = ~clk;

    // 0 always ready, 1 random, 2 held low
    always @(posedge clk) begin
        #1;
        case (ready_mode)
            1:       result_ready_i = (($random(ready_seed) & 3) != 0);
            2:       result_ready_i = 1'b0;
            default: result_ready_i = 1'b1;
        endcase
    end

    // --------------------
    // helpers
    // --------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic lsu_op_t make_op(input logic st, input mem_size_e sz, input logic sg,
                                        input word_t base, input word_t imm, input word_t data);
        lsu_op_t op;
        op                 = '0;
        op.store           = st;
        op.size            = sz;
        op.is_signed       = sg;
        op.rob_id          = next_rob;
        op.imm             = imm;
        op.data_opnd.valid = 1'b1;
        op.data_opnd.data  = data;
        op.base_opnd.valid = 1'b1;
        op.base_opnd.data  = base;
        next_rob           = next_rob + 1'b1;
        return op;
    endfunction

    // expected result from the address and memory rules, updates the model
    function automatic result_t ref_lsu(input lsu_op_t op);
        result_t    res;
        word_t      addr;
        word_t      w;
        word_t      v;
        logic [7:0] idx;
        int         off;
        int         nb;
        addr = op.base_opnd.data + op.imm;
        off  = int'(addr[1:0]);
        idx  = addr[9:2];
        case (op.size)
            SIZE_BYTE: nb = 1;
            SIZE_HALF: nb = 2;
            default:   nb = 4;
        endcase
        res.rob_id = op.rob_id;
        res.data   = '0;
        res.exc    = (off % nb) != 0;
        if (res.exc) begin
            return res;
        end
        w = mem_model[idx];
        if (op.store) begin
            for (int b = 0; b < nb; b++) begin
                w[(off + b) * 8 +: 8] = op.data_opnd.data[b * 8 +: 8];
            end
            mem_model[idx] = w;
        end else begin
            v = '0;
            for (int b = 0; b < nb; b++) begin
                v[b * 8 +: 8] = w[(off + b) * 8 +: 8];
            end
            if (op.is_signed && nb < 4 && v[nb * 8 - 1]) begin
                v = v | (32'hffff_ffff << (nb * 8));
            end
            res.data = v;
        end
        return res;
    endfunction

    function automatic lsu_op_t rand_op();
        integer    r;
        mem_size_e sz;
        word_t     addr;
        word_t     imm;
        r = $random(seed);
        case (r & 3)
            0:       sz = SIZE_BYTE;
            1:       sz = SIZE_HALF;
            default: sz = SIZE_WORD;
        endcase
        addr = 32'(($random(seed) & 15) * 4);
        if (sz == SIZE_BYTE) begin
            addr[1:0] = r[3:2];
        end else if (sz == SIZE_HALF) begin
            addr[1:0] = {r[3], 1'b0};
        end
        imm = 32'($random(seed) & 7) - 32'd4;
        return make_op(r[4], sz, r[5], addr - imm, imm, $random(seed));
    endfunction

    // expectation is taken in program order just before the transfer edge
    task automatic dispatch_ops(input dispatch_t d, input cdb_t [CDB_COUNT-1:0] cb,
                                input int max_wait, output bit sent);
        int        waited;
        dispatch_t drv;
        waited = 0;
        drv    = d;
        // waiting operands go out with junk data so only the CDB can supply it
        for (int s = 0; s < 2; s++) begin
            if (!d.slot[s].data_opnd.valid) begin
                drv.slot[s].data_opnd.data = ~d.slot[s].data_opnd.data;
            end
            if (!d.slot[s].base_opnd.valid) begin
                drv.slot[s].base_opnd.data = ~d.slot[s].base_opnd.data;
            end
        end
        while (!dispatch_ready_o && waited < max_wait) begin
            @(posedge clk);
            #1;
            waited++;
        end
        sent = dispatch_ready_o;
        if (sent) begin
            dispatch_i       = drv;
            dispatch_valid_i = 1'b1;
            cdb_i            = cb;
            for (int s = 0; s < 2; s++) begin
                if (d.mask[s]) begin
                    exp_q.push_back(ref_lsu(d.slot[s]));
                end
            end
            @(posedge clk);
            #1;
            dispatch_valid_i = 1'b0;
            dispatch_i       = '0;
            cdb_i            = NO_CDB;
        end
    endtask

    task automatic dispatch_one(input lsu_op_t op, input cdb_t [CDB_COUNT-1:0] cb);
        dispatch_t d;
        bit        sent;
        d         = '0;
        d.slot[0] = op;
        d.mask    = 2'b01;
        dispatch_ops(d, cb, WATCHDOG_CYCLES, sent);
    endtask

    task automatic broadcast(input int port, input rob_id_t tag, input word_t data);
        cdb_i[port].valid = 1'b1;
        cdb_i[port].tag   = tag;
        cdb_i[port].data  = data;
        @(posedge clk);
        #1;
        cdb_i = NO_CDB;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
            #1;
        end while (exp_q.size() != 0);
    endtask

    // --------------------
    // checker
    // --------------------
    always @(negedge clk) begin : monitor
        result_t exp_res;
        assert (lsu_top_i.lsu_properties_i.error_count == 0)
            else abort_run("a bound handshake property failed");
        if (rst_n_i && result_valid_o && result_ready_i) begin
            assert (exp_q.size() != 0)
                else abort_run($sformatf("result for rob %0d arrived with none expected",
                                         result_o.rob_id));
            exp_res = exp_q.pop_front();
            assert (result_o == exp_res)
                else abort_run($sformatf({"Mismatch at %0t: result_o rob=%0d data=%h exc=%b,",
                                          " expected rob=%0d data=%h exc=%b"}, $time,
                                         result_o.rob_id, result_o.data, result_o.exc,
                                         exp_res.rob_id, exp_res.data, exp_res.exc));
            results_seen++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles, results stopped coming",
                            WATCHDOG_CYCLES));
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin : main
        dispatch_t            d;
        lsu_op_t              op;
        cdb_t [CDB_COUNT-1:0] cb;
        word_t                val;
        int                   lane;
        int                   seen;
        int                   ops_sent;
        int                   waited;
        integer               r;
        bit                   sent;
        bit                   stalled;
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        dispatch_i       = '0;
        dispatch_valid_i = 1'b0;
        cdb_i            = NO_CDB;
        result_ready_i   = 1'b1;
        ready_mode       = 0;
        next_rob         = '0;
        results_seen     = 0;
        seed             = 32'hce13_459c;
        ready_seed       = 32'hce13_459c ^ 32'h5a5a_5a5a;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // memory is not cleared, so give the test region known words
        for (int i = 0; i < 16; i++) begin
            dispatch_one(make_op(1'b1, SIZE_WORD, 1'b0, 32'(i * 4), 32'h0, $random(seed)),
                         NO_CDB);
        end

        // word store then load back, negative immediate on the load
        dispatch_one(make_op(1'b1, SIZE_WORD, 1'b0, 32'h38, 32'h4, $random(seed)), NO_CDB);
        dispatch_one(make_op(1'b0, SIZE_WORD, 1'b0, 32'h40, 32'hffff_fffc, 32'h0), NO_CDB);
        wait_drain();

        // every byte and half lane, signed and unsigned
        for (lane = 0; lane < 4; lane++) begin
            val    = $random(seed);
            val[7] = ~lane[0];
            dispatch_one(make_op(1'b1, SIZE_BYTE, 1'b0, 32'h30, 32'(lane), val), NO_CDB);
            dispatch_one(make_op(1'b0, SIZE_BYTE, 1'b1, 32'h30, 32'(lane), 32'h0), NO_CDB);
            dispatch_one(make_op(1'b0, SIZE_BYTE, 1'b0, 32'h30, 32'(lane), 32'h0), NO_CDB);
        end
        for (lane = 0; lane < 4; lane += 2) begin
            val     = $random(seed);
            val[15] = ~lane[1];
            dispatch_one(make_op(1'b1, SIZE_HALF, 1'b0, 32'h34, 32'(lane), val), NO_CDB);
            dispatch_one(make_op(1'b0, SIZE_HALF, 1'b1, 32'h34, 32'(lane), 32'h0), NO_CDB);
            dispatch_one(make_op(1'b0, SIZE_HALF, 1'b0, 32'h34, 32'(lane), 32'h0), NO_CDB);
        end
        dispatch_one(make_op(1'b0, SIZE_WORD, 1'b0, 32'h30, 32'h0, 32'h0), NO_CDB);
        dispatch_one(make_op(1'b0, SIZE_WORD, 1'b0, 32'h34, 32'h0, 32'h0), NO_CDB);
        wait_drain();

        // base waits on tag 7 and must not complete before it
        seen                 = results_seen;
        op                   = make_op(1'b0, SIZE_WORD, 1'b0, 32'h0c, 32'h0, 32'h0);
        op.base_opnd.valid   = 1'b0;
        op.base_opnd.tag     = 5'd7;
        dispatch_one(op, NO_CDB);
        idle(6);
        assert (results_seen == seen)
            else abort_run("a load finished before its base tag was broadcast");
        broadcast(0, 5'd7, 32'h0c);
        wait_drain();

        // tag 9 on the CDB in the dispatch cycle, tag 11 blocks the head
        seen               = results_seen;
        val                = $random(seed);
        op                 = make_op(1'b1, SIZE_WORD, 1'b0, 32'h18, 32'h0, val);
        op.data_opnd.valid = 1'b0;
        op.data_opnd.tag   = 5'd9;
        cb                 = NO_CDB;
        cb[1].valid        = 1'b1;
        cb[1].tag          = 5'd9;
        cb[1].data         = val;
        dispatch_one(op, cb);
        op                 = make_op(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h8, 32'h0);
        op.base_opnd.valid = 1'b0;
        op.base_opnd.tag   = 5'd11;
        dispatch_one(op, NO_CDB);
        dispatch_one(make_op(1'b0, SIZE_BYTE, 1'b1, 32'h04, 32'h1, 32'h0), NO_CDB);
        idle(8);
        assert (results_seen == seen + 1)
            else abort_run("results passed a head entry still waiting on its tag");
        broadcast(1, 5'd11, 32'h10);
        wait_drain();

        // misaligned accesses leave memory alone
        dispatch_one(make_op(1'b1, SIZE_HALF, 1'b0, 32'h20, 32'h1, 32'hffff_ffff), NO_CDB);
        dispatch_one(make_op(1'b1, SIZE_WORD, 1'b0, 32'h20, 32'h2, 32'hffff_ffff), NO_CDB);
        dispatch_one(make_op(1'b0, SIZE_WORD, 1'b0, 32'h20, 32'h3, 32'h0), NO_CDB);
        dispatch_one(make_op(1'b0, SIZE_HALF, 1'b1, 32'h00, 32'h1, 32'h0), NO_CDB);
        dispatch_one(make_op(1'b0, SIZE_WORD, 1'b0, 32'h20, 32'h0, 32'h0), NO_CDB);
        wait_drain();

        // random mix with a stuttering result_ready_i
        ready_mode = 1;
        ops_sent   = 0;
        while (ops_sent < RAND_OPS) begin
            r         = $random(seed);
            d         = '0;
            d.slot[0] = rand_op();
            d.slot[1] = rand_op();
            case (r & 3)
                1:       d.mask = 2'b01;
                2:       d.mask = 2'b10;
                default: d.mask = 2'b11;
            endcase
            dispatch_ops(d, NO_CDB, WATCHDOG_CYCLES, sent);
            ops_sent += int'(d.mask[0]) + int'(d.mask[1]);
        end
        wait_drain();

        // fill everything with result_ready_i low until dispatch stalls
        ready_mode = 2;
        stalled    = 1'b0;
        for (int p = 0; p < FILL_PAIRS; p++) begin
            d         = '0;
            d.slot[0] = make_op(1'b0, SIZE_WORD, 1'b0, 32'((p % 16) * 4), 32'h0, 32'h0);
            d.slot[1] = make_op(1'b0, SIZE_BYTE, 1'b1, 32'((p % 16) * 4), 32'h3, 32'h0);
            d.mask    = 2'b11;
            dispatch_ops(d, NO_CDB, 20, sent);
            if (!sent) begin
                stalled = 1'b1;
                break;
            end
        end
        assert (stalled && !dispatch_ready_o)
            else abort_run("dispatch_ready_o never fell with the result port blocked");
        ready_mode = 0;

        // a full pipeline drains at one result per cycle, well inside this bound
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            idle(1);
            waited++;
        end
        idle(10);

        if (exp_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected results never arrived", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/lsu_pkg.sv
hw/iq_entry.sv
hw/lsu_iq.sv
hw/lsu_agu.sv
hw/stream_fifo.sv
hw/data_mem.sv
hw/lsu_top.sv
tests/lsu_properties.sv
tests/tb_lsu_top.sv

/* Makefile */
TOP := tb_lsu_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

# the run passes only if the pass line shows up in the output
run: compile
	./obj_dir/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
